/* com_link.f */
logic/com_link_pkg.sv
logic/com_tx.sv
logic/com_rx_sync.sv
logic/typec_rx.sv
logic/com_link.sv
test/tb_com_link.sv

/* logic/com_link.sv */
`timescale 1ns/1ps

module com_link #(
    parameter logic [3:0] SYNC_NIBBLE = 4'hA
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_fs,
    input  com_link_pkg::bag_type_e tx_btype,
    input  logic [3:0]              tx_didx,
    input  logic [3:0]              tx_freq,
    input  logic [3:0]              tx_ddidx,
    output logic                    tx_fd,
    output logic [7:0]              line_out,
    input  logic [7:0]              line_in,
    input  logic                    rx_fd,
    output logic                    rx_fs,
    output com_link_pkg::bag_type_e rx_btype,
    output logic [3:0]              rx_bdata,
    output logic                    rx_err,
    output logic                    rx_overrun
);

    import com_link_pkg::*;

    logic       frame_valid;
    logic       frame_err;
    bag_type_e  frame_type;
    logic [3:0] frame_data;

    com_tx #(
        .SYNC_NIBBLE(SYNC_NIBBLE)
    ) u_tx (
        .clk    (clk),
        .rst    (rst),
        .fs     (tx_fs),
        .fd     (tx_fd),
        .btype  (tx_btype),
        .didx   (tx_didx),
        .freq   (tx_freq),
        .ddidx  (tx_ddidx),
        .com_txd(line_out)
    );

    // line_in comes back from outside. the two paths share no state here.
    com_rx_sync #(
        .SYNC_NIBBLE(SYNC_NIBBLE)
    ) u_rx_sync (
        .clk        (clk),
        .rst        (rst),
        .com_rxd    (line_in),
        .frame_valid(frame_valid),
        .frame_err  (frame_err),
        .frame_type (frame_type),
        .frame_data (frame_data)
    );

    typec_rx u_rx_hold (
        .clk        (clk),
        .rst        (rst),
        .frame_valid(frame_valid),
        .frame_err  (frame_err),
        .frame_type (frame_type),
        .frame_data (frame_data),
        .fd         (rx_fd),
        .fs         (rx_fs),
        .btype      (rx_btype),
        .bdata      (rx_bdata),
        .err        (rx_err),
        .overrun    (rx_overrun)
    );

endmodule

/* logic/com_link_pkg.sv */
package com_link_pkg;

    // bag type opcode carried in the low nibble of every header byte.
    typedef enum logic [3:0] {
        BAG_INIT   = 4'd0,
        BAG_ACK    = 4'd1,
        BAG_NAK    = 4'd2,
        BAG_STALL  = 4'd3,
        BAG_DIDX   = 4'd5,
        BAG_DPARAM = 4'd6,
        BAG_DDIDX  = 4'd7,
        BAG_DLINK  = 4'd8,
        BAG_DTYPE  = 4'd9,
        BAG_DTEMP  = 4'd10,
        BAG_DHEAD  = 4'd12,
        BAG_DATA0  = 4'd13,
        BAG_DATA1  = 4'd14
    } bag_type_e;

    // encoder states of the transmit FSM.
    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,
        TX_HEAD = 2'd1,
        TX_DATA = 2'd2,
        TX_DONE = 2'd3
    } tx_state_e;

    // the receive synchronizer either hunts for a header or expects a data byte.
    typedef enum logic {
        SYNC_HUNT = 1'b0,
        SYNC_DATA = 1'b1
    } sync_state_e;

endpackage

/* logic/com_rx_sync.sv */
`timescale 1ns/1ps

module com_rx_sync #(
    parameter logic [3:0] SYNC_NIBBLE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [7:0]              com_rxd,
    output logic                    frame_valid,
    output logic                    frame_err,
    output com_link_pkg::bag_type_e frame_type,
    output logic [3:0]              frame_data
);

    import com_link_pkg::*;

    sync_state_e state;
    bag_type_e   hdr_type;
    logic        is_header;
    logic        data_ok;
    logic        take_header;

    assign hdr_type    = bag_type_e'(com_rxd[3:0]);
    assign is_header   = (com_rxd[7:4] == SYNC_NIBBLE);  // idle bytes never match.
    assign data_ok     = (com_rxd[7:4] == ~com_rxd[3:0]);
    assign take_header = (state == SYNC_HUNT) && is_header;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= SYNC_HUNT;
            frame_valid <= 1'b0;
            frame_err   <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_err   <= 1'b0;
            case (state)
                SYNC_HUNT: begin
                    if (is_header) begin
                        case (hdr_type)
                            BAG_ACK, BAG_NAK, BAG_STALL: begin
                                frame_valid <= 1'b1;
                            end
                            BAG_DIDX, BAG_DPARAM, BAG_DDIDX: begin
                                state <= SYNC_DATA;
                            end
                            default: begin
                                frame_err <= 1'b1;      // type not handled by this link.
                            end
                        endcase
                    end
                end
                SYNC_DATA: begin
                    state <= SYNC_HUNT;
                    if (data_ok) begin
                        frame_valid <= 1'b1;
                    end else begin
                        frame_err <= 1'b1;
                    end
                end
            endcase
        end
    end

    // type and data of the frame being received.
    always_ff @(posedge clk) begin
        if (take_header) begin
            frame_type <= hdr_type;
            frame_data <= 4'h0;
        end else if (state == SYNC_DATA) begin
            frame_data <= com_rxd[3:0];
        end
    end

endmodule

/* logic/com_tx.sv */
`timescale 1ns/1ps

module com_tx #(
    parameter logic [3:0] SYNC_NIBBLE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fs,
    output logic                    fd,
    input  com_link_pkg::bag_type_e btype,
    input  logic [3:0]              didx,
    input  logic [3:0]              freq,
    input  logic [3:0]              ddidx,
    output logic [7:0]              com_txd
);

    import com_link_pkg::*;

    tx_state_e  state;
    logic       start;
    logic       sel_data;
    logic [3:0] sel_nibble;
    logic       hold_data;
    logic [3:0] hold_nibble;

    // a start pulse while the frame is still going out is simply lost.
    assign start = fs && (state == TX_IDLE);

    // pick the field that rides in the data byte of the requested bag.
    always_comb begin
        sel_data   = 1'b1;
        sel_nibble = 4'h0;
        case (btype)
            BAG_DIDX: begin
                sel_nibble = didx;
            end
            BAG_DPARAM: begin
                sel_nibble = freq;
            end
            BAG_DDIDX: begin
                sel_nibble = ddidx;
            end
            default: begin
                sel_data = 1'b0;                        // header only.
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            com_txd <= 8'h00;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (start) begin
                        state   <= TX_HEAD;
                        com_txd <= {SYNC_NIBBLE, btype};
                    end
                end
                TX_HEAD: begin
                    if (hold_data) begin
                        state   <= TX_DATA;
                        com_txd <= {~hold_nibble, hold_nibble}; // upper nibble is the check.
                    end else begin
                        state   <= TX_DONE;
                        com_txd <= 8'h00;
                    end
                end
                TX_DATA: begin
                    state   <= TX_DONE;
                    com_txd <= 8'h00;
                end
                TX_DONE: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // the field is frozen at start so the caller may change its inputs afterwards.
    always_ff @(posedge clk) begin
        if (start) begin
            hold_data   <= sel_data;
            hold_nibble <= sel_nibble;
        end
    end

    assign fd = (state == TX_DONE);                     // one cycle after the last byte.

endmodule

/* logic/typec_rx.sv */
`timescale 1ns/1ps

module typec_rx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_valid,
    input  logic                    frame_err,
    input  com_link_pkg::bag_type_e frame_type,
    input  logic [3:0]              frame_data,
    input  logic                    fd,
    output logic                    fs,
    output com_link_pkg::bag_type_e btype,
    output logic [3:0]              bdata,
    output logic                    err,
    output logic                    overrun
);

    import com_link_pkg::*;

    logic accept;
    logic drop;

    assign accept = frame_valid && !fs;
    assign drop   = frame_valid && fs;                  // consumer has not released the last one.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs      <= 1'b0;
            btype   <= BAG_INIT;
            bdata   <= 4'h0;
            err     <= 1'b0;
            overrun <= 1'b0;
        end else begin
            err <= frame_err;
            if (accept) begin
                fs    <= 1'b1;
                btype <= frame_type;
                bdata <= frame_data;
            end else if (fs && fd) begin
                fs <= 1'b0;                             // released by the consumer.
            end
            if (drop) begin
                overrun <= 1'b1;                        // sticky until reset.
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile the testbench and the link with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

rm -rf build/obj_dir build/sim.log

mkdir -p build &&
verilator --binary --timing -f com_link.f --top-module tb_com_link \
    -Mdir build/obj_dir -o sim_tb &&
./build/obj_dir/sim_tb > build/sim.log 2>&1 ||
echo "build or simulation returned an error"

cat build/sim.log 2>/dev/null

grep -q "Simulation completed successfully" build/sim.log 2>/dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

exit 0

/* test/tb_com_link.sv */
`timescale 1ns/1ps

module tb_com_link;

    import com_link_pkg::*;

    localparam int NUM_ROWS      = 11;
    localparam int TIMEOUT_LIMIT = 20;
    localparam int DROP_ROW      = 9;

    logic       clk;
    logic       rst;
    logic       tx_fs;
    bag_type_e  tx_btype;
    logic [3:0] tx_didx;
    logic [3:0] tx_freq;
    logic [3:0] tx_ddidx;
    logic       tx_fd;
    logic [7:0] line_out;
    logic [7:0] line_in;
    logic       rx_fd;
    logic       rx_fs;
    bag_type_e  rx_btype;
    logic [3:0] rx_bdata;
    logic       rx_err;
    logic       rx_overrun;
    logic [7:0] corrupt_mask;

    bag_type_e  row_btype    [NUM_ROWS];
    logic [3:0] row_didx     [NUM_ROWS];
    logic [3:0] row_freq     [NUM_ROWS];
    logic [3:0] row_ddidx    [NUM_ROWS];
    logic       row_corrupt  [NUM_ROWS];
    logic       row_hold     [NUM_ROWS];
    bag_type_e  row_exp_type [NUM_ROWS];
    logic [3:0] row_exp_data [NUM_ROWS];
    logic       row_exp_err  [NUM_ROWS];

    int   seed;
    int   errors;
    int   timeouts;
    int   start_cyc;
    int   cyc           = 0;
    int   tx_fd_count   = 0;
    int   rx_rise_count = 0;
    int   rx_err_count  = 0;
    logic rx_fs_prev    = 1'b0;
    logic overrun_expected;

    com_link UUT (
        .clk       (clk),
        .rst       (rst),
        .tx_fs     (tx_fs),
        .tx_btype  (tx_btype),
        .tx_didx   (tx_didx),
        .tx_freq   (tx_freq),
        .tx_ddidx  (tx_ddidx),
        .tx_fd     (tx_fd),
        .line_out  (line_out),
        .line_in   (line_in),
        .rx_fd     (rx_fd),
        .rx_fs     (rx_fs),
        .rx_btype  (rx_btype),
        .rx_bdata  (rx_bdata),
        .rx_err    (rx_err),
        .rx_overrun(rx_overrun)
    );

    assign line_in = line_out ^ corrupt_mask;           // loopback with optional bit flips.

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // pulse counters sample in mid cycle where every output is settled.
    always @(negedge clk) begin
        if (tx_fd) begin
            tx_fd_count <= tx_fd_count + 1;
        end
        if (rx_err) begin
            rx_err_count <= rx_err_count + 1;
        end
        if (rx_fs && !rx_fs_prev) begin
            rx_rise_count <= rx_rise_count + 1;
        end
        rx_fs_prev <= rx_fs;
    end

    function automatic logic has_data_byte(input bag_type_e btype);
        return (btype == BAG_DIDX) || (btype == BAG_DPARAM) || (btype == BAG_DDIDX);
    endfunction

    function automatic logic rx_event(input logic dropped);
        if (dropped) begin
            return rx_overrun;                          // a dropped frame only shows as overrun.
        end
        return rx_fs || rx_err;
    endfunction

    task automatic check_type(input string what, input bag_type_e got, input bag_type_e exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_data(input string what, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one table row with random field nibbles and the data nibble the bag should carry.
    task automatic set_row(input int r, input bag_type_e btype, input logic corrupt,
                           input logic hold, input logic exp_err);
        int rnd;
        rnd             = $random(seed);
        row_btype[r]    = btype;
        row_didx[r]     = rnd[3:0];
        row_freq[r]     = rnd[7:4];
        row_ddidx[r]    = rnd[11:8];
        row_corrupt[r]  = corrupt;
        row_hold[r]     = hold;
        row_exp_type[r] = btype;
        row_exp_err[r]  = exp_err;
        case (btype)
            BAG_DIDX:   row_exp_data[r] = row_didx[r];
            BAG_DPARAM: row_exp_data[r] = row_freq[r];
            BAG_DDIDX:  row_exp_data[r] = row_ddidx[r];
            default:    row_exp_data[r] = 4'h0;
        endcase
    endtask

    task automatic build_table();
        set_row(0, BAG_ACK, 1'b0, 1'b0, 1'b0);
        set_row(1, BAG_NAK, 1'b0, 1'b0, 1'b0);
        set_row(2, BAG_STALL, 1'b0, 1'b0, 1'b0);
        set_row(3, BAG_DIDX, 1'b0, 1'b0, 1'b0);
        set_row(4, BAG_DPARAM, 1'b0, 1'b0, 1'b0);
        set_row(5, BAG_DDIDX, 1'b0, 1'b0, 1'b0);
        set_row(6, BAG_DPARAM, 1'b1, 1'b0, 1'b1);
        set_row(7, BAG_DTEMP, 1'b0, 1'b0, 1'b1);
        set_row(8, BAG_DDIDX, 1'b0, 1'b1, 1'b0);
        set_row(DROP_ROW, BAG_NAK, 1'b0, 1'b0, 1'b0);
        set_row(10, BAG_STALL, 1'b0, 1'b0, 1'b0);
        row_exp_type[DROP_ROW] = row_exp_type[DROP_ROW - 1]; // the held frame stays visible.
        row_exp_data[DROP_ROW] = row_exp_data[DROP_ROW - 1];
    endtask

    task automatic step_cycle(input int r);
        int offs;
        @(posedge clk);
        #1;
        offs  = cyc - start_cyc;
        tx_fs = (offs == 2);                            // second start while the encoder is busy.
        if (row_corrupt[r] && offs == 2) begin
            corrupt_mask = 8'h40;                       // the data byte is on the line now.
        end else begin
            corrupt_mask = 8'h00;
        end
    endtask

    task automatic wait_tx_done(input int r);
        int waited;
        waited = 0;
        while (!tx_fd && waited < TIMEOUT_LIMIT) begin
            step_cycle(r);
            waited++;
        end
        if (!tx_fd) begin
            $display("Timeout in row %0d: the transmitter never signalled done.", r);
            timeouts++;
        end else begin
            check_count("tx_fd latency", cyc - start_cyc, has_data_byte(row_btype[r]) ? 3 : 2);
        end
    endtask

    task automatic run_row(input int r);
        int   fd_before;
        int   rise_before;
        int   err_before;
        int   waited;
        logic dropped;
        // a frame from the last row is still held.
        dropped     = (r > 0) && row_hold[r - 1] && !row_exp_err[r - 1];
        fd_before   = tx_fd_count;
        rise_before = rx_rise_count;
        err_before  = rx_err_count;
        tx_btype    = row_btype[r];
        tx_didx     = row_didx[r];
        tx_freq     = row_freq[r];
        tx_ddidx    = row_ddidx[r];
        start_cyc   = cyc;
        tx_fs       = 1'b1;
        wait_tx_done(r);
        waited = 0;
        while (!rx_event(dropped) && waited < TIMEOUT_LIMIT) begin
            step_cycle(r);
            waited++;
        end
        if (!rx_event(dropped)) begin
            $display("Timeout in row %0d: the receiver showed no frame, error or overrun.", r);
            timeouts++;
        end else begin
            if (dropped) begin
                overrun_expected = 1'b1;
            end
            check_flag("rx_err", rx_err, row_exp_err[r]);
            check_flag("rx_overrun", rx_overrun, overrun_expected);
            if (row_exp_err[r]) begin
                check_flag("rx_fs", rx_fs, 1'b0);
            end else begin
                check_flag("rx_fs", rx_fs, 1'b1);
                check_type("rx_btype", rx_btype, row_exp_type[r]);
                check_data("rx_bdata", rx_bdata, row_exp_data[r]);
                if (!dropped) begin
                    check_count("rx_fs latency", cyc - start_cyc,
                                has_data_byte(row_btype[r]) ? 4 : 3);
                end
            end
        end
        if (!row_exp_err[r] && !row_hold[r]) begin
            rx_fd = 1'b1;
            step_cycle(r);
            rx_fd = 1'b0;
            check_flag("rx_fs after rx_fd", rx_fs, 1'b0);
        end
        repeat (3) step_cycle(r);                       // let the link drain before counting.
        check_count("tx_fd pulses", tx_fd_count - fd_before, 1);
        check_count("rx_fs rises", rx_rise_count - rise_before,
                    (row_exp_err[r] || dropped) ? 0 : 1);
        check_count("rx_err pulses", rx_err_count - err_before, row_exp_err[r] ? 1 : 0);
    endtask

    initial begin
        seed             = 32'hf3c9;
        errors           = 0;
        timeouts         = 0;
        start_cyc        = 0;
        overrun_expected = 1'b0;
        rst              = 1'b1;
        tx_fs            = 1'b0;
        tx_btype         = BAG_INIT;
        tx_didx          = 4'h0;
        tx_freq          = 4'h0;
        tx_ddidx         = 4'h0;
        rx_fd            = 1'b0;
        corrupt_mask     = 8'h00;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("tx_fd after reset", tx_fd, 1'b0);
        check_flag("rx_fs after reset", rx_fs, 1'b0);
        check_flag("rx_err after reset", rx_err, 1'b0);
        check_flag("rx_overrun after reset", rx_overrun, 1'b0);
        check_data("line_out high nibble after reset", line_out[7:4], 4'h0);
        check_data("line_out low nibble after reset", line_out[3:0], 4'h0);
        check_type("rx_btype after reset", rx_btype, BAG_INIT);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
